/* run_sim.sh */
#!/bin/sh
# build and run the device bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dev_bus -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_dev_bus)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^test passed$"; then
	exit 0
fi

echo "pass message not found in the output"
exit 1

/* sim.f */
source/dev_pkg.sv
source/dev_decoder.sv
source/dev_slot.sv
source/dev_collect.sv
source/dev_bus_top.sv
test/tb_dev_bus.sv

/* source/dev_bus_top.sv */
`timescale 1ns/1ns

module dev_bus_top (
	input logic clk_cpu,
	input logic reset_i,
	input logic req_i,
	input dev_pkg::bus_req_t req_data_i,
	output logic ack_o,
	output dev_pkg::bus_rsp_t rsp_o,
	output logic [dev_pkg::NUM_SLOTS-1:0] irq_o
	);

	// decoder to slots
	logic [dev_pkg::NUM_SLOTS-1:0] acc_stb;
	dev_pkg::slot_acc_t acc;

	// slots to collector
	logic [dev_pkg::NUM_SLOTS-1:0] rsp_vld;
	logic [dev_pkg::NUM_SLOTS-1:0][dev_pkg::DATA_W-1:0] rsp_data;

	// decoder and collector handshake
	logic err_stb;
	logic done;

	dev_decoder u_decoder (
		.clk_cpu(clk_cpu),
		.reset_i(reset_i),
		.req_i(req_i),
		.req_data_i(req_data_i),
		.done_i(done),
		.acc_stb_o(acc_stb),
		.acc_o(acc),
		.err_stb_o(err_stb)
		);

	// one device per slot, slot n drives irq_o[n]
	for (genvar n = 0; n < dev_pkg::NUM_SLOTS; n++) begin : g_slot
		dev_slot u_slot (
			.clk_cpu(clk_cpu),
			.reset_i(reset_i),
			.acc_stb_i(acc_stb[n]),
			.acc_i(acc),
			.rsp_vld_o(rsp_vld[n]),
			.rsp_data_o(rsp_data[n]),
			.irq_o(irq_o[n])
			);
	end

	dev_collect u_collect (
		.clk_cpu(clk_cpu),
		.reset_i(reset_i),
		.req_i(req_i),
		.rsp_vld_i(rsp_vld),
		.rsp_data_i(rsp_data),
		.err_stb_i(err_stb),
		.ack_o(ack_o),
		.rsp_o(rsp_o),
		.done_o(done)
		);

endmodule

/* source/dev_collect.sv */
`timescale 1ns/1ns

module dev_collect (
	input logic clk_cpu,
	input logic reset_i,
	input logic req_i,
	input logic [dev_pkg::NUM_SLOTS-1:0] rsp_vld_i,
	input logic [dev_pkg::NUM_SLOTS-1:0][dev_pkg::DATA_W-1:0] rsp_data_i,
	input logic err_stb_i,
	output logic ack_o,
	output dev_pkg::bus_rsp_t rsp_o,
	output logic done_o
	);

	dev_pkg::col_state_t state;

	logic any_vld;
	logic [dev_pkg::DATA_W-1:0] sel_word;

	assign any_vld = |rsp_vld_i;

	// pick the answering slot, at most one valid bit is set
	always_comb begin
		sel_word = '0;
		for (int i = 0; i < dev_pkg::NUM_SLOTS; i++) begin
			if (rsp_vld_i[i])
				sel_word = sel_word | rsp_data_i[i];
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			state <= dev_pkg::COL_IDLE;
			ack_o <= 1'b0;
			rsp_o <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				dev_pkg::COL_IDLE: begin
					if (err_stb_i) begin
						rsp_o.rdata <= '0;
						rsp_o.err <= 1'b1;
						ack_o <= 1'b1;
						state <= dev_pkg::COL_ACK;
					end else if (any_vld) begin
						rsp_o.rdata <= sel_word;
						rsp_o.err <= 1'b0;
						ack_o <= 1'b1;
						state <= dev_pkg::COL_ACK;
					end
				end
				dev_pkg::COL_ACK: begin
					// response holds while the host keeps req_i up
					if (!req_i) begin
						ack_o <= 1'b0;
						rsp_o <= '0;
						done_o <= 1'b1;
						state <= dev_pkg::COL_DROP;
					end
				end
				dev_pkg::COL_DROP: begin
					// done pulse is out, decoder returns to idle
					state <= dev_pkg::COL_IDLE;
				end
				default: begin
					state <= dev_pkg::COL_IDLE;
				end
			endcase
		end
	end

endmodule

/* source/dev_decoder.sv */
`timescale 1ns/1ns

module dev_decoder (
	input logic clk_cpu,
	input logic reset_i,
	input logic req_i,
	input dev_pkg::bus_req_t req_data_i,
	input logic done_i,
	output logic [dev_pkg::NUM_SLOTS-1:0] acc_stb_o,
	output dev_pkg::slot_acc_t acc_o,
	output logic err_stb_o
	);

	dev_pkg::dec_state_t state;

	logic take;
	logic [dev_pkg::SLOT_FIELD_W-1:0] slot_field;
	logic bad_slot;
	logic bad_pad;

	// captured with the request
	logic [dev_pkg::SLOT_IDX_W-1:0] slot_q;
	logic err_q;

	// error pulse lags one cycle, like a slot response
	logic err_dly;

	logic [dev_pkg::NUM_SLOTS-1:0] stb_onehot;

	// a request is only taken from idle, a held req_i in wait is ignored
	assign take = (state == dev_pkg::DEC_IDLE) && req_i;

	// address fields
	assign slot_field = req_data_i.addr[dev_pkg::ADDR_W-1:dev_pkg::SLOT_ADDR_W];
	assign bad_slot = slot_field >= dev_pkg::SLOT_LIMIT;
	assign bad_pad = |req_data_i.addr[dev_pkg::SLOT_ADDR_W-1:dev_pkg::PAD_LSB];

	always_comb begin
		stb_onehot = '0;
		stb_onehot[slot_q] = 1'b1;
	end

	// payload capture
	always_ff @(posedge clk_cpu) begin
		if (take) begin
			slot_q <= slot_field[dev_pkg::SLOT_IDX_W-1:0];
			err_q <= bad_slot | bad_pad;
			acc_o.reg_id <= dev_pkg::reg_id_t'(
				req_data_i.addr[dev_pkg::PAD_LSB-1:dev_pkg::REG_LSB]);
			acc_o.we <= req_data_i.we;
			acc_o.sel <= req_data_i.sel;
			acc_o.wdata <= req_data_i.wdata;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			state <= dev_pkg::DEC_IDLE;
			acc_stb_o <= '0;
			err_stb_o <= 1'b0;
			err_dly <= 1'b0;
		end else begin
			// strobes last one cycle
			acc_stb_o <= '0;
			err_stb_o <= err_dly;
			err_dly <= 1'b0;
			case (state)
				dev_pkg::DEC_IDLE: begin
					if (req_i)
						state <= dev_pkg::DEC_ISSUE;
				end
				dev_pkg::DEC_ISSUE: begin
					// bad address goes to the collector one cycle later
					if (err_q)
						err_dly <= 1'b1;
					else
						acc_stb_o <= stb_onehot;
					state <= dev_pkg::DEC_WAIT;
				end
				dev_pkg::DEC_WAIT: begin
					// hold until the host has closed the handshake
					if (done_i)
						state <= dev_pkg::DEC_IDLE;
				end
				default: begin
					state <= dev_pkg::DEC_IDLE;
				end
			endcase
		end
	end

endmodule

/* source/dev_pkg.sv */
package dev_pkg;

	// host bus widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 16;
	localparam int SEL_W = 4;
	localparam int BYTE_W = DATA_W / SEL_W;

	// slot map, each device owns 256 bytes of the window
	localparam int SLOT_ADDR_W = 8;
	localparam int SLOT_FIELD_W = ADDR_W - SLOT_ADDR_W;
	localparam int NUM_SLOTS = 4;
	localparam int SLOT_IDX_W = 2;
	localparam logic [SLOT_FIELD_W-1:0] SLOT_LIMIT = SLOT_FIELD_W'(NUM_SLOTS);

	// word select inside a slot, bits between PAD_LSB and the slot field must be zero
	localparam int REG_LSB = 2;
	localparam int PAD_LSB = 4;

	// scratch words per device
	localparam int NUM_SCRATCH = 3;

	typedef enum logic [1:0] {
		REG_DATA0 = 2'd0,
		REG_DATA1 = 2'd1,
		REG_DATA2 = 2'd2,
		REG_IRQ = 2'd3
	} reg_id_t;

	typedef enum logic [1:0] {
		DEC_IDLE = 2'd0,
		DEC_ISSUE = 2'd1,
		DEC_WAIT = 2'd2
	} dec_state_t;

	typedef enum logic [1:0] {
		COL_IDLE = 2'd0,
		COL_ACK = 2'd1,
		COL_DROP = 2'd2
	} col_state_t;

	// request from the host, 53 bits
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic we;
		logic [SEL_W-1:0] sel;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	// response to the host, 33 bits
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic err;
	} bus_rsp_t;

	// access handed to one slot, 39 bits
	typedef struct packed {
		reg_id_t reg_id;
		logic we;
		logic [SEL_W-1:0] sel;
		logic [DATA_W-1:0] wdata;
	} slot_acc_t;

endpackage

/* source/dev_slot.sv */
`timescale 1ns/1ns

module dev_slot (
	input logic clk_cpu,
	input logic reset_i,
	input logic acc_stb_i,
	input dev_pkg::slot_acc_t acc_i,
	output logic rsp_vld_o,
	output logic [dev_pkg::DATA_W-1:0] rsp_data_o,
	output logic irq_o
	);

	logic [dev_pkg::NUM_SCRATCH-1:0][dev_pkg::DATA_W-1:0] scratch;
	logic [dev_pkg::DATA_W-1:0] rd_word;
	logic is_irq;
	logic do_write;

	assign is_irq = (acc_i.reg_id == dev_pkg::REG_IRQ);
	assign do_write = acc_stb_i && acc_i.we;

	// read mux, irq sits in bit 0
	always_comb begin
		if (is_irq)
			rd_word = {{(dev_pkg::DATA_W-1){1'b0}}, irq_o};
		else
			rd_word = scratch[acc_i.reg_id];
	end

	// register state
	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			scratch <= '0;
			irq_o <= 1'b0;
		end else if (do_write) begin
			if (is_irq) begin
				// only byte lane 0 reaches the irq bit
				if (acc_i.sel[0])
					irq_o <= acc_i.wdata[0];
			end else begin
				for (int b = 0; b < dev_pkg::SEL_W; b++) begin
					if (acc_i.sel[b])
						scratch[acc_i.reg_id][b*dev_pkg::BYTE_W +: dev_pkg::BYTE_W] <=
							acc_i.wdata[b*dev_pkg::BYTE_W +: dev_pkg::BYTE_W];
				end
			end
		end
	end

	// response one cycle after the strobe
	always_ff @(posedge clk_cpu) begin
		if (reset_i)
			rsp_vld_o <= 1'b0;
		else
			rsp_vld_o <= acc_stb_i;
	end

	always_ff @(posedge clk_cpu) begin
		if (acc_stb_i) begin
			// writes answer with zero
			if (acc_i.we)
				rsp_data_o <= '0;
			else
				rsp_data_o <= rd_word;
		end
	end

endmodule

/* test/tb_dev_bus.sv */
`timescale 1ns/1ns

module tb_dev_bus;

	localparam int NUM_ACCESSES = 110;
	localparam int CYCLE_LIMIT = 20 * NUM_ACCESSES + 50;
	localparam int NUM_REGS = 4;

	logic clk_cpu;
	logic reset_i;
	logic req_i;
	dev_pkg::bus_req_t req_data;
	logic ack_o;
	dev_pkg::bus_rsp_t rsp_o;
	logic [dev_pkg::NUM_SLOTS-1:0] irq_o;

	// reference state of every device
	logic [31:0] model_scr [dev_pkg::NUM_SLOTS][3];
	logic model_irq [dev_pkg::NUM_SLOTS];

	int cycles;

	dev_bus_top dut0 (
		.clk_cpu(clk_cpu),
		.reset_i(reset_i),
		.req_i(req_i),
		.req_data_i(req_data),
		.ack_o(ack_o),
		.rsp_o(rsp_o),
		.irq_o(irq_o)
		);

	initial begin
		clk_cpu = 1'b0;
		forever #50 clk_cpu = ~clk_cpu;
	end

	always @(posedge clk_cpu) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [15:0] reg_addr(input int slot, input int r);
		return {slot[7:0], 4'h0, r[1:0], 2'b00};
	endfunction

	function automatic logic [31:0] model_read(input int slot, input int r);
		if (r == 3)
			return {31'b0, model_irq[slot]};
		return model_scr[slot][r];
	endfunction

	function automatic logic [31:0] model_irq_vec();
		logic [31:0] v;
		v = '0;
		for (int s = 0; s < dev_pkg::NUM_SLOTS; s++)
			v[s] = model_irq[s];
		return v;
	endfunction

	// four-phase exchange, also times ack_o rise and fall
	task automatic bus_access(input logic [15:0] addr, input logic we, input logic [3:0] sel,
		input logic [31:0] wdata, input int hold, output dev_pkg::bus_rsp_t rsp);
		int lat;
		int drop;
		@(posedge clk_cpu);
		req_data.addr <= addr;
		req_data.we <= we;
		req_data.sel <= sel;
		req_data.wdata <= wdata;
		req_i <= 1'b1;
		// first edge that samples req_i high
		@(posedge clk_cpu);
		lat = 0;
		do begin
			@(posedge clk_cpu);
			lat++;
			@(negedge clk_cpu);
		end while (!ack_o);
		check_eq(lat, 3, "ack_o latency");
		rsp = rsp_o;
		for (int i = 0; i < hold; i++) begin
			@(negedge clk_cpu);
			check_eq(32'(ack_o), 1, "ack_o held");
			check_eq(rsp_o.rdata, rsp.rdata, "rsp_o data held");
			check_eq(32'(rsp_o.err), 32'(rsp.err), "rsp_o error held");
		end
		@(posedge clk_cpu);
		req_i <= 1'b0;
		drop = 0;
		do begin
			@(posedge clk_cpu);
			drop++;
			@(negedge clk_cpu);
		end while (ack_o);
		check_eq(drop, 1, "ack_o fall delay");
	endtask

	task automatic write_reg(input int slot, input int r, input logic [3:0] sel,
		input logic [31:0] data, input int hold);
		dev_pkg::bus_rsp_t rsp;
		bus_access(reg_addr(slot, r), 1'b1, sel, data, hold, rsp);
		check_eq(32'(rsp.err), 0, "write error flag");
		check_eq(rsp.rdata, 0, "write read data");
		if (r == 3) begin
			if (sel[0])
				model_irq[slot] = data[0];
		end else begin
			for (int b = 0; b < 4; b++)
				if (sel[b])
					model_scr[slot][r][8*b +: 8] = data[8*b +: 8];
		end
	endtask

	task automatic read_check(input int slot, input int r, input int hold);
		dev_pkg::bus_rsp_t rsp;
		bus_access(reg_addr(slot, r), 1'b0, 4'hf, 32'h0, hold, rsp);
		check_eq(32'(rsp.err), 0, "read error flag");
		check_eq(rsp.rdata, model_read(slot, r), $sformatf("read slot %0d reg %0d", slot, r));
	endtask

	task automatic read_all();
		for (int s = 0; s < dev_pkg::NUM_SLOTS; s++)
			for (int r = 0; r < NUM_REGS; r++)
				read_check(s, r, 0);
	endtask

	task automatic test_reset();
		@(negedge clk_cpu);
		check_eq(32'(ack_o), 0, "ack_o after reset");
		check_eq(32'(irq_o), 0, "irq_o after reset");
		read_all();
	endtask

	task automatic test_full_word();
		for (int s = 0; s < dev_pkg::NUM_SLOTS; s++)
			for (int r = 0; r < 3; r++)
				write_reg(s, r, 4'hf, $urandom, 0);
		for (int s = 0; s < dev_pkg::NUM_SLOTS; s++)
			for (int r = 0; r < 3; r++)
				read_check(s, r, 0);
	endtask

	task automatic test_byte_enables();
		for (int s = 0; s < dev_pkg::NUM_SLOTS; s++)
			for (int r = 0; r < 3; r++)
				write_reg(s, r, 4'($urandom), $urandom, 0);
		for (int s = 0; s < dev_pkg::NUM_SLOTS; s++)
			for (int r = 0; r < 3; r++)
				read_check(s, r, 0);
	endtask

	task automatic test_irq();
		for (int s = 0; s < dev_pkg::NUM_SLOTS; s++) begin
			write_reg(s, 3, {3'($urandom), 1'b1}, 32'h1, 0);
			check_eq(32'(irq_o), model_irq_vec(), "irq_o after set");
			read_check(s, 3, 0);
			// lane 0 disabled, bit must stay
			write_reg(s, 3, {3'($urandom), 1'b0}, 32'h0, 0);
			check_eq(32'(irq_o), model_irq_vec(), "irq_o after masked write");
			read_check(s, 3, 0);
			write_reg(s, 3, 4'hf, 32'h0, 0);
			check_eq(32'(irq_o), model_irq_vec(), "irq_o after clear");
			read_check(s, 3, 0);
		end
	endtask

	task automatic test_errors();
		logic [15:0] bad_addr [4];
		dev_pkg::bus_rsp_t rsp;
		bad_addr[0] = 16'h0400;
		bad_addr[1] = 16'hff08;
		bad_addr[2] = 16'h0110;
		bad_addr[3] = 16'h02f4;
		for (int i = 0; i < 4; i++) begin
			bus_access(bad_addr[i], 1'b1, 4'hf, $urandom, 0, rsp);
			check_eq(32'(rsp.err), 1, $sformatf("error flag for %h", bad_addr[i]));
			check_eq(rsp.rdata, 0, $sformatf("error data for %h", bad_addr[i]));
		end
		read_all();
	endtask

	task automatic test_backpressure();
		write_reg(2, 1, 4'hf, $urandom, 10);
		read_check(2, 1, 10);
	endtask

	initial begin
		reset_i = 1'b1;
		req_i = 1'b0;
		req_data = '0;
		cycles = 0;
		void'($urandom(32'h9467_ca99));
		for (int s = 0; s < dev_pkg::NUM_SLOTS; s++) begin
			model_irq[s] = 1'b0;
			for (int r = 0; r < 3; r++)
				model_scr[s][r] = '0;
		end
		repeat (3) @(posedge clk_cpu);
		reset_i <= 1'b0;
		test_reset();
		test_full_word();
		test_byte_enables();
		test_irq();
		test_errors();
		test_backpressure();
		$display("test passed");
		$finish;
	end

endmodule
